// File: tb.f
+incdir+tb
hw/radio_pkg.sv
hw/timekeeper.sv
hw/sample_fifo.sv
hw/radio_ctrl.sv
hw/rx_framer.sv
hw/tx_deframer.sv
hw/radio_block_top.sv
tb/tb_radio_block.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_radio_block
FILELIST   := tb.f
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/1ps
SIM_FLAGS  := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Pass message not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb/tb_radio_tasks.svh
// Directed tests of the radio block and their settings bus and stream helpers
// Included inside the testbench module and uses its signals directly
`default_nettype none

task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
  @(posedge clk);
  #(DRIVE_DLY);
  set_stb  = 1'b1;
  set_addr = addr;
  set_data = data;
  @(posedge clk);
  #(DRIVE_DLY);
  set_stb = 1'b0;
endtask

task automatic read_back(input rb_sel_e sel, output logic [63:0] value);
  write_setting(SR_RB_SEL, 32'(sel));
  value = rb_data;
endtask

// Rx command word from timed flag, opcode and sample count
function automatic logic [31:0] rx_cmd_word(input logic timed, input rx_cmd_e op,
                                            input int count);
  return {timed, op, 1'b0, count[27:0]};
endfunction

task automatic clear_rx_log();
  rx_words.delete();
  drv_samps.delete();
  drv_times.delete();
endtask

task automatic pulse_pps();
  @(posedge clk);
  #(DRIVE_DLY);
  pps = 1'b1;
  repeat (2) @(posedge clk);
  #(DRIVE_DLY);
  pps = 1'b0;
  @(posedge clk);
  #(DRIVE_DLY);
endtask

// One random sample per cycle with run_rx low before run_from
task automatic strobe_rx(input int n, input logic [63:0] run_from);
  int i;
  for (i = 0; i < n; i++) begin
    @(posedge clk);
    #(DRIVE_DLY);
    rx_samp = $urandom;
    rx_stb  = 1'b1;
    @(negedge clk);
    drv_samps.push_back(rx_samp);
    drv_times.push_back(vita_time);
    assert (vita_time >= run_from || !run_rx)
      else report_error($sformatf("run_rx high at time %0h before %0h", vita_time, run_from));
  end
  @(posedge clk);
  #(DRIVE_DLY);
  rx_stb = 1'b0;
endtask

task automatic wait_rx_words(input int n, input string what);
  int cnt;
  cnt = 0;
  while (rx_words.size() < n) begin
    @(posedge clk);
    cnt++;
    if (cnt > WAIT_MAX) begin
      abort_on_timeout(what);
    end
  end
  // Give stray words a chance to show up
  repeat (4) @(posedge clk);
  #(DRIVE_DLY);
endtask

task automatic compare_words(input int count, input int first, input int last_at);
  int k;
  logic [32:0] expect_word;
  assert (rx_words.size() == count)
    else report_error($sformatf("got %0d rx words, expected %0d", rx_words.size(), count));
  for (k = 0; k < count; k++) begin
    expect_word = {(k == last_at), drv_samps[first + k]};
    assert (rx_words[k] == expect_word)
      else report_error($sformatf("rx word %0d is %0h, expected %0h", k, rx_words[k],
                                  expect_word));
  end
endtask

task automatic check_time_and_pps();
  logic [63:0] t_set;
  logic [63:0] value;
  logic [63:0] lo;
  logic [63:0] hi;
  logic [63:0] c0;
  t_set = 64'h0000_0012_3456_0000;
  write_setting(SR_TIME_HI, t_set[63:32]);
  write_setting(SR_TIME_LO, t_set[31:0]);
  c0 = cycles;
  write_setting(SR_TIME_CTRL, 32'h1);
  read_back(RB_VITA_NOW, value);
  assert (value >= t_set && value <= t_set + (cycles - c0))
    else report_error($sformatf("time now %0h, loaded %0h", value, t_set));

  lo = vita_time;
  pulse_pps();
  hi = vita_time;
  read_back(RB_VITA_LASTPPS, value);
  assert (value >= lo && value <= hi)
    else report_error($sformatf("PPS time %0h outside [%0h, %0h]", value, lo, hi));

  // Load armed for the next PPS edge
  t_set = 64'h0000_00ab_0000_1000;
  write_setting(SR_TIME_HI, t_set[63:32]);
  write_setting(SR_TIME_LO, t_set[31:0]);
  write_setting(SR_TIME_CTRL, 32'h2);
  assert (vita_time < t_set) else report_error("time loaded before the PPS edge");
  c0 = cycles;
  pulse_pps();
  value = vita_time;
  assert (value >= t_set && value <= t_set + (cycles - c0))
    else report_error($sformatf("time after PPS load %0h, loaded %0h", value, t_set));
endtask

task automatic fixed_count_burst(input int n);
  clear_rx_log();
  write_setting(SR_RX_CMD, rx_cmd_word(1'b0, CMD_NUM_SAMPS, n));
  strobe_rx(n + 4, '0);
  wait_rx_words(n, "fixed burst words");
  compare_words(n, 0, n - 1);
  assert (!run_rx) else report_error("run_rx still high after fixed burst");
endtask

task automatic timed_burst(input int n);
  logic [63:0] t_cmd;
  int i;
  int first;
  clear_rx_log();
  t_cmd = vita_time + 64'd30;
  write_setting(SR_RX_TIME_HI, t_cmd[63:32]);
  write_setting(SR_RX_TIME_LO, t_cmd[31:0]);
  write_setting(SR_RX_CMD, rx_cmd_word(1'b1, CMD_NUM_SAMPS, n));
  strobe_rx(48, t_cmd);
  wait_rx_words(n, "timed burst words");
  assert (burst_time >= t_cmd && burst_time < t_cmd + 64'd2)
    else report_error($sformatf("burst time %0h, command time %0h", burst_time, t_cmd));
  first = -1;
  for (i = 0; i < drv_times.size(); i++) begin
    if (first < 0 && drv_times[i] == burst_time) begin
      first = i;
    end
  end
  assert (first >= 0) else report_error("burst time matches no strobed sample");
  compare_words(n, first, n - 1);
  assert (!run_rx) else report_error("run_rx still high after timed burst");
endtask

task automatic continuous_then_stop(input int m);
  clear_rx_log();
  write_setting(SR_RX_CMD, rx_cmd_word(1'b0, CMD_CONTINUOUS, 0));
  strobe_rx(m, '0);
  write_setting(SR_RX_CMD, rx_cmd_word(1'b0, CMD_STOP, 0));
  // Strobes after the stop are not captured
  strobe_rx(4, '0);
  wait_rx_words(m, "continuous words");
  compare_words(m, 0, -1);
  assert (!run_rx) else report_error("run_rx still high after stop");
endtask

task automatic rx_overflow_drain(input int n);
  logic [63:0] st;
  clear_rx_log();
  rx_tready = 1'b0;
  write_setting(SR_RX_CMD, rx_cmd_word(1'b0, CMD_CONTINUOUS, 0));
  strobe_rx(n, '0);
  read_back(RB_STATUS, st);
  assert (st[RB_STAT_OVF_BIT]) else report_error("overflow bit not set");
  assert (st[RB_STAT_STATE_LSB +: 2] == 2'(RX_IDLE))
    else report_error($sformatf("rx state %0d after overflow", st[RB_STAT_STATE_LSB +: 2]));
  assert (!run_rx) else report_error("run_rx still high after overflow");
  assert (rx_tvalid) else report_error("rx tvalid low with words buffered");
  rx_tready = 1'b1;
  wait_rx_words(DEPTH, "buffered words after overflow");
  compare_words(DEPTH, 0, -1);
  write_setting(SR_RX_CMD, rx_cmd_word(1'b0, CMD_STOP, 0));
  read_back(RB_STATUS, st);
  assert (!st[RB_STAT_OVF_BIT]) else report_error("overflow bit not cleared by command");
endtask

task automatic tx_stream_underflow(input int k);
  logic [31:0] tx_samps[$];
  logic [31:0] expect_word;
  logic [63:0] st;
  int i;
  int cnt;
  for (i = 0; i < k; i++) begin
    tx_samps.push_back($urandom);
  end
  // Stream source holding each word until accepted
  for (i = 0; i < k; i++) begin
    @(posedge clk);
    #(DRIVE_DLY);
    tx_tdata  = tx_samps[i];
    tx_tvalid = 1'b1;
    cnt = 0;
    @(negedge clk);
    while (!tx_tready) begin
      cnt++;
      if (cnt > WAIT_MAX) begin
        abort_on_timeout("tx stream ready");
      end
      @(negedge clk);
    end
  end
  @(posedge clk);
  #(DRIVE_DLY);
  tx_tvalid = 1'b0;
  assert (tx_dac == 32'h0 && !run_tx) else report_error("DAC word changed with tx off");

  write_setting(SR_TX_CTRL, 32'h1);
  assert (run_tx) else report_error("run_tx not set");
  for (i = 0; i < k + 2; i++) begin
    expect_word = (i < k) ? tx_samps[i] : 32'h0;
    @(posedge clk);
    #(DRIVE_DLY);
    tx_stb = 1'b1;
    @(posedge clk);
    #(DRIVE_DLY);
    tx_stb = 1'b0;
    assert (tx_dac == expect_word)
      else report_error($sformatf("DAC word %0d is %0h, expected %0h", i, tx_dac, expect_word));
    @(posedge clk);
    #(DRIVE_DLY);
    assert (tx_dac == expect_word)
      else report_error($sformatf("DAC word %0d not held between strobes", i));
  end
  read_back(RB_STATUS, st);
  assert (st[RB_STAT_UNF_BIT]) else report_error("underflow bit not set");
  write_setting(SR_TX_CTRL, 32'h0);
  read_back(RB_STATUS, st);
  assert (!st[RB_STAT_UNF_BIT] && !run_tx)
    else report_error("underflow bit not cleared by tx control write");
endtask

`default_nettype wire

// File: tb/tb_radio_block.sv
// Testbench for the radio block with clock, reset, DUT, rx stream sink and test sequence
// Directed tests come from the included task file
`default_nettype none

module tb_radio_block;
  timeunit 1ns;
  timeprecision 1ps;
  import radio_pkg::*;

  localparam int          FIFO_AW   = 4;
  localparam int          DEPTH     = 1 << FIFO_AW;
  localparam int          CLK_HALF  = 20;
  localparam int          DRIVE_DLY = 2;
  localparam int          WAIT_MAX  = 200;
  localparam logic [31:0] RAND_SEED = 32'h57ce_c9f6;

  logic        clk;
  logic        rst_n;
  logic        pps;
  logic        set_stb;
  logic [7:0]  set_addr;
  logic [31:0] set_data;
  logic [31:0] rx_samp;
  logic        rx_stb;
  logic        tx_stb;
  logic        rx_tready;
  logic [31:0] tx_tdata;
  logic        tx_tvalid;
  logic [63:0] rb_data;
  logic [63:0] vita_time;
  logic        run_rx;
  logic        run_tx;
  logic [31:0] tx_dac;
  logic [31:0] rx_tdata;
  logic        rx_tlast;
  logic        rx_tvalid;
  logic [63:0] burst_time;
  logic        tx_tready;
  logic [63:0] cycles;

  // Words taken from the rx stream as {tlast, tdata}
  logic [32:0] rx_words[$];
  // Samples driven on rx strobes and the time each one meets at its edge
  logic [31:0] drv_samps[$];
  logic [63:0] drv_times[$];

  //////////////////////////////
  // Clock and cycle count
  //////////////////////////////
  initial clk = 1'b0;
  always #(CLK_HALF) clk = ~clk;

  initial cycles = '0;
  always @(posedge clk) cycles <= cycles + 64'd1;

  radio_block_top #(
    .FIFO_AW(FIFO_AW))
  UUT (
    .i_ce_clk(clk), .i_rst_n(rst_n), .i_pps(pps),
    .i_set_stb(set_stb), .i_set_addr(set_addr), .i_set_data(set_data),
    .o_rb_data(rb_data),
    .i_rx(rx_samp), .i_rx_stb(rx_stb), .i_tx_stb(tx_stb), .o_tx(tx_dac),
    .o_vita_time(vita_time), .o_run_rx(run_rx), .o_run_tx(run_tx),
    .o_rx_tdata(rx_tdata), .o_rx_tlast(rx_tlast), .o_rx_tvalid(rx_tvalid),
    .i_rx_tready(rx_tready), .o_rx_burst_time(burst_time),
    .i_tx_tdata(tx_tdata), .i_tx_tvalid(tx_tvalid), .o_tx_tready(tx_tready));

  // Rx sink taking each transfer mid-cycle before its rising edge
  always @(negedge clk) begin
    if (rst_n && rx_tvalid && rx_tready) begin
      rx_words.push_back({rx_tlast, rx_tdata});
    end
  end

  task automatic report_error(input string msg);
    $display("ERROR at %0d ns: %s", $time, msg);
    $display("Simulation failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic abort_on_timeout(input string what);
    $display("Timed out after %0d cycles while waiting for %s", WAIT_MAX, what);
    $display("Simulation failed");
    $fatal(1, "Stopped on a timeout");
  endtask

  `include "tb_radio_tasks.svh"

  //////////////////////////////
  // Test sequence
  //////////////////////////////
  initial begin
    void'($urandom(RAND_SEED));
    rst_n     = 1'b0;
    pps       = 1'b0;
    set_stb   = 1'b0;
    set_addr  = '0;
    set_data  = '0;
    rx_samp   = '0;
    rx_stb    = 1'b0;
    tx_stb    = 1'b0;
    rx_tready = 1'b1;
    tx_tdata  = '0;
    tx_tvalid = 1'b0;
    repeat (4) @(posedge clk);
    #(DRIVE_DLY);
    rst_n = 1'b1;

    assert (!run_rx && !run_tx && !rx_tvalid && tx_tready && tx_dac == 32'h0)
      else report_error("outputs not idle after reset");

    check_time_and_pps();
    fixed_count_burst(12);
    timed_burst(8);
    continuous_then_stop(10);
    rx_overflow_drain(DEPTH + 4);
    tx_stream_underflow(6);

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/radio_block_top.sv
// Single-channel radio block: timekeeper, control, rx capture and tx playout
// Programmed through the settings bus, samples move on valid/ready streams
`default_nettype none

module radio_block_top #(
  parameter int FIFO_AW = 4
) (
  input  logic                         i_ce_clk,
  input  logic                         i_rst_n,
  input  logic                         i_pps,
  // Settings bus
  input  logic                         i_set_stb,
  input  logic [7:0]                   i_set_addr,
  input  logic [31:0]                  i_set_data,
  output logic [radio_pkg::TIME_W-1:0] o_rb_data,
  // Front end
  input  logic [radio_pkg::SAMP_W-1:0] i_rx,
  input  logic                         i_rx_stb,
  input  logic                         i_tx_stb,
  output logic [radio_pkg::SAMP_W-1:0] o_tx,
  output logic [radio_pkg::TIME_W-1:0] o_vita_time,
  output logic                         o_run_rx,
  output logic                         o_run_tx,
  // Rx sample stream
  output logic [radio_pkg::SAMP_W-1:0] o_rx_tdata,
  output logic                         o_rx_tlast,
  output logic                         o_rx_tvalid,
  input  logic                         i_rx_tready,
  output logic [radio_pkg::TIME_W-1:0] o_rx_burst_time,
  // Tx sample stream
  input  logic [radio_pkg::SAMP_W-1:0] i_tx_tdata,
  input  logic                         i_tx_tvalid,
  output logic                         o_tx_tready
);
  import radio_pkg::*;

  logic [TIME_W-1:0] vita_time_lastpps;
  logic              rx_last;
  logic              overflow;
  logic              underflow;

  //////////////////////////////
  // Time and control
  //////////////////////////////
  timekeeper inst_timekeeper (
    .i_ce_clk(i_ce_clk), .i_rst_n(i_rst_n), .i_pps(i_pps),
    .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
    .o_vita_time(o_vita_time), .o_vita_time_lastpps(vita_time_lastpps));

  radio_ctrl inst_radio_ctrl (
    .i_ce_clk(i_ce_clk), .i_rst_n(i_rst_n),
    .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
    .i_vita_time(o_vita_time), .i_vita_time_lastpps(vita_time_lastpps),
    .i_rx_stb(i_rx_stb), .i_overflow(overflow), .i_underflow(underflow),
    .o_run_rx(o_run_rx), .o_rx_last(rx_last), .o_run_tx(o_run_tx),
    .o_rb_data(o_rb_data));

  //////////////////////////////
  // Sample paths
  //////////////////////////////
  rx_framer #(
    .FIFO_AW(FIFO_AW))
  inst_rx_framer (
    .i_ce_clk(i_ce_clk), .i_rst_n(i_rst_n),
    .i_run(o_run_rx), .i_last(rx_last), .i_rx(i_rx), .i_rx_stb(i_rx_stb),
    .i_vita_time(o_vita_time), .i_rx_tready(i_rx_tready),
    .o_rx_tdata(o_rx_tdata), .o_rx_tlast(o_rx_tlast), .o_rx_tvalid(o_rx_tvalid),
    .o_rx_burst_time(o_rx_burst_time), .o_overflow(overflow));

  tx_deframer #(
    .FIFO_AW(FIFO_AW))
  inst_tx_deframer (
    .i_ce_clk(i_ce_clk), .i_rst_n(i_rst_n),
    .i_run(o_run_tx), .i_tx_stb(i_tx_stb),
    .i_tx_tdata(i_tx_tdata), .i_tx_tvalid(i_tx_tvalid), .o_tx_tready(o_tx_tready),
    .o_tx(o_tx), .o_underflow(underflow));

endmodule

`default_nettype wire

// File: hw/tx_deframer.sv
// Tx playout: buffers the incoming sample stream and feeds the DAC word on tx strobes
// An empty buffer at a strobe sends zero and reports underflow
`default_nettype none

module tx_deframer #(
  parameter int FIFO_AW = 4
) (
  input  logic                         i_ce_clk,
  input  logic                         i_rst_n,
  input  logic                         i_run,
  input  logic                         i_tx_stb,
  input  logic [radio_pkg::SAMP_W-1:0] i_tx_tdata,
  input  logic                         i_tx_tvalid,
  output logic                         o_tx_tready,
  output logic [radio_pkg::SAMP_W-1:0] o_tx,
  output logic                         o_underflow
);
  import radio_pkg::*;

  logic            fifo_full;
  logic            fifo_empty;
  logic            dac_stb;
  logic            pop;
  logic [SAMP_W:0] head;

  assign o_tx_tready = !fifo_full;
  assign dac_stb     = i_run && i_tx_stb;
  assign pop         = dac_stb && !fifo_empty;
  assign o_underflow = dac_stb && fifo_empty;

  // Tx stream has no framing, so the flag bit stays clear
  sample_fifo #(
    .FIFO_AW(FIFO_AW))
  inst_fifo (
    .i_ce_clk  (i_ce_clk),
    .i_rst_n   (i_rst_n),
    .i_wr_en   (i_tx_tvalid),
    .i_wr_data ({1'b0, i_tx_tdata}),
    .i_rd_en   (pop),
    .o_rd_data (head),
    .o_empty   (fifo_empty),
    .o_full    (fifo_full));

  // DAC word holds between strobes
  always_ff @(posedge i_ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_tx <= '0;
    end else if (dac_stb) begin
      if (fifo_empty) begin
        o_tx <= '0;
      end else begin
        o_tx <= head[SAMP_W-1:0];
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/rx_framer.sv
// Rx capture: buffers strobed ADC samples and sends them out as a valid/ready stream
// Tags the final sample of a burst, records the burst start time, flags overflow
`default_nettype none

module rx_framer #(
  parameter int FIFO_AW = 4
) (
  input  logic                         i_ce_clk,
  input  logic                         i_rst_n,
  input  logic                         i_run,
  input  logic                         i_last,
  input  logic [radio_pkg::SAMP_W-1:0] i_rx,
  input  logic                         i_rx_stb,
  input  logic [radio_pkg::TIME_W-1:0] i_vita_time,
  input  logic                         i_rx_tready,
  output logic [radio_pkg::SAMP_W-1:0] o_rx_tdata,
  output logic                         o_rx_tlast,
  output logic                         o_rx_tvalid,
  output logic [radio_pkg::TIME_W-1:0] o_rx_burst_time,
  output logic                         o_overflow
);
  import radio_pkg::*;

  logic            wr_req;
  logic            in_burst;
  logic            fifo_full;
  logic            fifo_empty;
  logic [SAMP_W:0] head;

  // Every strobe while running carries a sample
  assign wr_req     = i_run && i_rx_stb;
  // Sample lost because the stream side is not keeping up
  assign o_overflow = wr_req && fifo_full;

  // Marks that the first sample of this burst has been seen
  always_ff @(posedge i_ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      in_burst <= 1'b0;
    end else if (!i_run) begin
      in_burst <= 1'b0;
    end else if (wr_req) begin
      in_burst <= 1'b1;
    end
  end

  // Time stamp of the first captured sample
  always_ff @(posedge i_ce_clk) begin
    if (wr_req && !in_burst) begin
      o_rx_burst_time <= i_vita_time;
    end
  end

  sample_fifo #(
    .FIFO_AW(FIFO_AW))
  inst_fifo (
    .i_ce_clk  (i_ce_clk),
    .i_rst_n   (i_rst_n),
    .i_wr_en   (wr_req),
    .i_wr_data ({i_last, i_rx}),
    .i_rd_en   (i_rx_tready && o_rx_tvalid),
    .o_rd_data (head),
    .o_empty   (fifo_empty),
    .o_full    (fifo_full));

  // Stream side straight off the FIFO head
  assign o_rx_tvalid = !fifo_empty;
  assign o_rx_tdata  = head[SAMP_W-1:0];
  assign o_rx_tlast  = head[SAMP_W];

endmodule

`default_nettype wire

// File: hw/radio_ctrl.sv
// Radio control: rx command engine, tx enable, sticky error flags and readback mux
// Listens to the settings bus for the rx, tx and readback addresses only
`default_nettype none

module radio_ctrl (
  input  logic                         i_ce_clk,
  input  logic                         i_rst_n,
  input  logic                         i_set_stb,
  input  logic [7:0]                   i_set_addr,
  input  logic [31:0]                  i_set_data,
  input  logic [radio_pkg::TIME_W-1:0] i_vita_time,
  input  logic [radio_pkg::TIME_W-1:0] i_vita_time_lastpps,
  input  logic                         i_rx_stb,
  input  logic                         i_overflow,
  input  logic                         i_underflow,
  output logic                         o_run_rx,
  output logic                         o_rx_last,
  output logic                         o_run_tx,
  output logic [radio_pkg::TIME_W-1:0] o_rb_data
);
  import radio_pkg::*;

  rx_state_e         rx_state;
  rx_cmd_e           rx_mode;
  rx_cmd_e           cmd_op;
  logic              cmd_timed;
  logic [CNT_W-1:0]  samps_left;
  logic [TIME_W-1:0] cmd_time;
  logic              rx_cmd_wr;
  logic              tx_ctrl_wr;
  logic              overflow;
  logic              underflow;
  rb_sel_e           rb_sel;
  logic [TIME_W-1:0] status;

  //////////////////////////////
  // Settings decode
  //////////////////////////////
  assign rx_cmd_wr  = i_set_stb && (i_set_addr == SR_RX_CMD);
  assign tx_ctrl_wr = i_set_stb && (i_set_addr == SR_TX_CTRL);
  assign cmd_op     = rx_cmd_e'(i_set_data[RX_CMD_OP_LSB +: 2]);
  assign cmd_timed  = i_set_data[RX_CMD_TIMED_BIT];

  // Command start time
  always_ff @(posedge i_ce_clk) begin
    if (i_set_stb && (i_set_addr == SR_RX_TIME_HI)) begin
      cmd_time[TIME_W-1:32] <= i_set_data;
    end
    if (i_set_stb && (i_set_addr == SR_RX_TIME_LO)) begin
      cmd_time[31:0] <= i_set_data;
    end
  end

  //////////////////////////////
  // Rx command FSM
  //////////////////////////////
  assign o_run_rx  = (rx_state == RX_RUN);
  // Strobe carrying the final sample of a counted burst
  assign o_rx_last = o_run_rx && i_rx_stb && (rx_mode == CMD_NUM_SAMPS) &&
                     (samps_left == CNT_W'(1));

  always_ff @(posedge i_ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rx_state   <= RX_IDLE;
      rx_mode    <= CMD_STOP;
      samps_left <= '0;
      overflow   <= 1'b0;
    end else if (rx_cmd_wr) begin
      overflow   <= 1'b0;
      rx_mode    <= cmd_op;
      samps_left <= i_set_data[CNT_W-1:0];
      case (cmd_op)
        CMD_NUM_SAMPS, CMD_CONTINUOUS: rx_state <= cmd_timed ? RX_WAIT_TIME : RX_RUN;
        default:                       rx_state <= RX_IDLE;
      endcase
    end else begin
      if (i_overflow) begin
        overflow <= 1'b1;
      end
      case (rx_state)
        RX_WAIT_TIME: begin
          if (i_vita_time >= cmd_time) begin
            rx_state <= RX_RUN;
          end
        end
        RX_RUN: begin
          if (i_overflow || o_rx_last) begin
            rx_state <= RX_IDLE;
          end else if (i_rx_stb && (rx_mode == CMD_NUM_SAMPS)) begin
            samps_left <= samps_left - 1'b1;
          end
        end
        default: rx_state <= RX_IDLE;
      endcase
    end
  end

  //////////////////////////////
  // Tx enable, readback select
  //////////////////////////////
  always_ff @(posedge i_ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_run_tx  <= 1'b0;
      underflow <= 1'b0;
      rb_sel    <= RB_VITA_NOW;
    end else begin
      if (tx_ctrl_wr) begin
        o_run_tx  <= i_set_data[TX_CTRL_RUN_BIT];
        underflow <= 1'b0;
      end else if (i_underflow) begin
        underflow <= 1'b1;
      end
      if (i_set_stb && (i_set_addr == SR_RB_SEL)) begin
        rb_sel <= rb_sel_e'(i_set_data[1:0]);
      end
    end
  end

  always_comb begin
    status                                   = '0;
    status[RB_STAT_OVF_BIT]                  = overflow;
    status[RB_STAT_UNF_BIT]                  = underflow;
    status[RB_STAT_STATE_LSB +: 2]           = rx_state;
  end

  always_comb begin
    case (rb_sel)
      RB_VITA_NOW:     o_rb_data = i_vita_time;
      RB_VITA_LASTPPS: o_rb_data = i_vita_time_lastpps;
      RB_STATUS:       o_rb_data = status;
      default:         o_rb_data = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: hw/sample_fifo.sv
// Ring buffer FIFO of samples with a last flag, head word shown while not empty
// Shared by the rx capture path and the tx playout path
`default_nettype none

module sample_fifo #(
  parameter int FIFO_AW = 4
) (
  input  logic                       i_ce_clk,
  input  logic                       i_rst_n,
  input  logic                       i_wr_en,
  input  logic [radio_pkg::SAMP_W:0] i_wr_data,
  input  logic                       i_rd_en,
  output logic [radio_pkg::SAMP_W:0] o_rd_data,
  output logic                       o_empty,
  output logic                       o_full
);
  import radio_pkg::*;

  localparam int DEPTH = 1 << FIFO_AW;

  logic [SAMP_W:0]  mem [DEPTH];
  // Extra top bit tells a full buffer from an empty one
  logic [FIFO_AW:0] wr_ptr;
  logic [FIFO_AW:0] rd_ptr;

  assign o_empty   = (wr_ptr == rd_ptr);
  assign o_full    = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
                     (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);
  assign o_rd_data = mem[rd_ptr[FIFO_AW-1:0]];

  always_ff @(posedge i_ce_clk) begin
    if (i_wr_en && !o_full) begin
      mem[wr_ptr[FIFO_AW-1:0]] <= i_wr_data;
    end
  end

  always_ff @(posedge i_ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (i_wr_en && !o_full) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (i_rd_en && !o_empty) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/timekeeper.sv
// Radio time counter, stepping once per clock
// Loaded from the settings bus either at once or on the next PPS rising edge
`default_nettype none

module timekeeper (
  input  logic                         i_ce_clk,
  input  logic                         i_rst_n,
  input  logic                         i_pps,
  input  logic                         i_set_stb,
  input  logic [7:0]                   i_set_addr,
  input  logic [31:0]                  i_set_data,
  output logic [radio_pkg::TIME_W-1:0] o_vita_time,
  output logic [radio_pkg::TIME_W-1:0] o_vita_time_lastpps
);
  import radio_pkg::*;

  logic [TIME_W-1:0] pending_time;
  logic              ctrl_wr;
  logic              pps_d;
  logic              pps_edge;
  logic              load_arm;

  assign ctrl_wr  = i_set_stb && (i_set_addr == SR_TIME_CTRL);
  assign pps_edge = i_pps && !pps_d;

  // Time to be loaded, written in two halves
  always_ff @(posedge i_ce_clk) begin
    if (i_set_stb && (i_set_addr == SR_TIME_HI)) begin
      pending_time[TIME_W-1:32] <= i_set_data;
    end
    if (i_set_stb && (i_set_addr == SR_TIME_LO)) begin
      pending_time[31:0] <= i_set_data;
    end
  end

  always_ff @(posedge i_ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pps_d               <= 1'b0;
      load_arm            <= 1'b0;
      o_vita_time         <= '0;
      o_vita_time_lastpps <= '0;
    end else begin
      pps_d <= i_pps;

      if (pps_edge) begin
        o_vita_time_lastpps <= o_vita_time;
      end

      // A direct load wins over a pending PPS load
      if (ctrl_wr && i_set_data[TIME_CTRL_NOW_BIT]) begin
        o_vita_time <= pending_time;
        load_arm    <= 1'b0;
      end else if (ctrl_wr) begin
        o_vita_time <= o_vita_time + 1'b1;
        load_arm    <= i_set_data[TIME_CTRL_PPS_BIT];
      end else if (load_arm && pps_edge) begin
        o_vita_time <= pending_time;
        load_arm    <= 1'b0;
      end else begin
        o_vita_time <= o_vita_time + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/radio_pkg.sv
// Shared definitions for the radio block: settings bus addresses, register fields,
// command and readback encodings, and the datapath widths
`default_nettype none

package radio_pkg;

  // Datapath widths
  localparam int SAMP_W = 32;
  localparam int TIME_W = 64;
  localparam int CNT_W  = 28;

  // Timekeeper settings addresses
  localparam logic [7:0] SR_TIME_HI    = 8'd128;
  localparam logic [7:0] SR_TIME_LO    = 8'd129;
  localparam logic [7:0] SR_TIME_CTRL  = 8'd130;

  // Radio control settings addresses
  localparam logic [7:0] SR_RX_CMD     = 8'd160;
  localparam logic [7:0] SR_RX_TIME_HI = 8'd161;
  localparam logic [7:0] SR_RX_TIME_LO = 8'd162;
  localparam logic [7:0] SR_TX_CTRL    = 8'd163;
  localparam logic [7:0] SR_RB_SEL     = 8'd164;

  // Bit positions inside the settings words
  localparam int TIME_CTRL_NOW_BIT = 0;
  localparam int TIME_CTRL_PPS_BIT = 1;
  localparam int RX_CMD_TIMED_BIT  = 31;
  localparam int RX_CMD_OP_LSB     = 29;
  localparam int TX_CTRL_RUN_BIT   = 0;

  // Status readback layout
  localparam int RB_STAT_OVF_BIT   = 0;
  localparam int RB_STAT_UNF_BIT   = 1;
  localparam int RB_STAT_STATE_LSB = 2;

  typedef enum logic [1:0] {
    CMD_STOP       = 2'd0,
    CMD_NUM_SAMPS  = 2'd1,
    CMD_CONTINUOUS = 2'd2
  } rx_cmd_e;

  typedef enum logic [1:0] {
    RB_VITA_NOW     = 2'd0,
    RB_VITA_LASTPPS = 2'd1,
    RB_STATUS       = 2'd2
  } rb_sel_e;

  typedef enum logic [1:0] {
    RX_IDLE      = 2'd0,
    RX_WAIT_TIME = 2'd1,
    RX_RUN       = 2'd2
  } rx_state_e;

endpackage

`default_nettype wire
